//--- coco_pkg.sv
// coco bus glue shared types
package coco_pkg;

  // machine configuration straps
  typedef struct packed {
    logic turbo;     // double-speed enable cadence
    logic dragon;    // dragon 32/64 memory map
    logic dragon64;  // dragon 64 extras, acia and rom banks
  } machine_cfg_t;

  // cpu address as seen by the rom chips
  typedef struct packed {
    logic [2:0]  page;    // 8k page
    logic [12:0] offset;  // byte within the 8k rom
  } rom_addr_t;

  // cpu address as seen by the pia and acia
  typedef struct packed {
    logic [12:0] page;
    logic        serial;  // a2, pia0 or acia on the dragon 64
    logic [1:0]  rs;      // register select
  } io_addr_t;

  // one 16-bit cpu address, two readings
  typedef union packed {
    rom_addr_t rom;
    io_addr_t  io;
  } cpu_addr_u;

  // one-hot chip selects
  typedef struct packed {
    logic ram;
    logic rom8;
    logic roma;
    logic romc;
    logic pia0;
    logic pia1;
    logic io;
    logic acia;     // dragon 64 only
    logic rom8_b1;  // dragon 64 bank selects
    logic rom8_b2;
    logic roma_b1;
    logic roma_b2;
  } chip_sel_t;

  // read-source bytes, _alt is dragon 64 bank 2
  typedef struct packed {
    logic [7:0] ram;
    logic [7:0] rom8;
    logic [7:0] roma;
    logic [7:0] romc;
    logic [7:0] pia0;
    logic [7:0] pia1;
    logic [7:0] io;
    logic [7:0] acia;
    logic [7:0] rom8_alt;
    logic [7:0] roma_alt;
  } rd_src_t;

  // sam timing strobes
  typedef struct packed {
    logic ras_n;
    logic cas_n;
    logic e;
    logic q;
  } dram_strobe_t;

  // joystick position for the comparator dac
  typedef struct packed {
    logic [7:0] x;
    logic [7:0] y;
  } joy_pos_t;

  localparam logic [7:0] JOY_CENTER = 8'd128;
  localparam logic [7:0] JOY_LOW    = 8'd16;   // left or up
  localparam logic [7:0] JOY_HIGH   = 8'd240;  // right or down

  localparam logic [7:0] FLOAT_BYTE = 8'hFF;  // open bus read

endpackage

//--- clk_enable_gen.sv
// system clock enable generator
module clk_enable_gen #(
  parameter int FAST_DIV = 2,
  parameter int SLOW_DIV = 3
) (
  input  logic clk,
  input  logic reset_n,
  input  logic turbo,    // picks the fast cadence
  output logic clk_ena
);

  // wide enough for the larger divisor
  localparam int CNT_W = $clog2(((FAST_DIV > SLOW_DIV) ? FAST_DIV : SLOW_DIV) + 1);

  // g_div[0] slow, g_div[1] fast
  for (genvar i = 0; i < 2; i++)
  begin : g_div
    localparam int DIV = (i == 0) ? SLOW_DIV : FAST_DIV;

    logic [CNT_W-1:0] cnt;  // free running
    logic             wrap;
    logic             pulse;  // one clock wide, registered

    assign wrap = (cnt == CNT_W'(DIV - 1));

    always_ff @(posedge clk)
    begin
      if (!reset_n)
      begin
        cnt   <= '0;
        pulse <= 1'b0;
      end
      else
      begin
        pulse <= wrap;  // lands on the DIV-th clock
        if (wrap)
          cnt <= '0;
        else
          cnt <= cnt + 1'b1;
      end
    end
  end

  assign clk_ena = turbo ? g_div[1].pulse : g_div[0].pulse;

endmodule

//--- chip_select_decode.sv
// device select decoder
module chip_select_decode (
  input  coco_pkg::machine_cfg_t cfg,
  input  logic [2:0]             dev_sel,  // from the sam
  input  coco_pkg::cpu_addr_u    addr,
  input  logic                   ddrb2,    // pia1 port b direction bit 2
  input  logic                   portb2,   // pia1 port b data bit 2
  output coco_pkg::chip_sel_t    sel
);

  logic [6:0] cs_138;  // active-high 138 outputs, y7 unused
  logic       bank1;
  logic       bank2;
  logic       d64;

  // 74ls138 style one-of-eight
  always_comb
  begin
    case (dev_sel)
      3'd0:    cs_138 = 7'b000_0001;  // ram
      3'd1:    cs_138 = 7'b000_0010;  // rom8 8000
      3'd2:    cs_138 = 7'b000_0100;  // roma a000
      3'd3:    cs_138 = 7'b000_1000;  // romc cart
      3'd4:    cs_138 = 7'b001_0000;  // pia0 ff00
      3'd5:    cs_138 = 7'b010_0000;  // pia1 ff20
      3'd6:    cs_138 = 7'b100_0000;  // io ff40
      default: cs_138 = 7'b000_0000;  // nothing mapped
    endcase
  end

  assign d64 = cfg.dragon64;

  // undriven pb2 floats high through the pull-up
  // so only an output driving low reaches bank 2
  assign bank1 = ~ddrb2 | portb2;
  assign bank2 = ddrb2 & ~portb2;

  always_comb
  begin
    sel.ram  = cs_138[0];
    sel.rom8 = cs_138[1] & ~d64;  // banked on the d64
    sel.roma = cs_138[2] & ~d64;
    sel.romc = cs_138[3];
    sel.pia1 = cs_138[5];
    sel.io   = cs_138[6];

    // pia0 window shared with the acia by a2
    sel.pia0 = cs_138[4] & (~d64 | ~addr.io.serial);
    sel.acia = cs_138[4] & d64 & addr.io.serial;

    // rom bank selects, low on the coco
    sel.rom8_b1 = cs_138[1] & d64 & bank1;
    sel.rom8_b2 = cs_138[1] & d64 & bank2;
    sel.roma_b1 = cs_138[2] & d64 & bank1;
    sel.roma_b2 = cs_138[2] & d64 & bank2;
  end

endmodule

//--- bus_latch.sv
// dram address and read data latch
module bus_latch (
  input  logic                   clk,
  input  logic                   reset_n,
  input  logic                   clk_ena,
  input  coco_pkg::dram_strobe_t strobes,
  input  logic [7:0]             dram_addr_byte,  // muxed row or column
  input  coco_pkg::rd_src_t      src,
  output coco_pkg::rd_src_t      held,
  output logic [15:0]            sam_addr,
  output logic [7:0]             video_byte
);

  // strobe levels at the last enable
  logic ras_n_r;
  logic cas_n_r;
  logic q_r;

  logic ras_rise;
  logic ras_fall;
  logic cas_fall;
  logic q_rise;

  // edges on the enable grid only
  assign ras_rise = strobes.ras_n & ~ras_n_r;
  assign ras_fall = ~strobes.ras_n & ras_n_r;
  assign cas_fall = ~strobes.cas_n & cas_n_r;
  assign q_rise   = strobes.q & ~q_r;

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      ras_n_r    <= 1'b0;
      cas_n_r    <= 1'b0;
      q_r        <= 1'b0;
      held       <= '0;
      sam_addr   <= '0;
      video_byte <= '0;
    end
    else if (clk_ena)
    begin
      // end of ras cycle during e, cpu data now stable
      if (ras_rise && strobes.e)
        held <= src;

      // row first, then column
      if (ras_fall)
        sam_addr[7:0] <= dram_addr_byte;
      else if (cas_fall)
        sam_addr[15:8] <= dram_addr_byte;

      // vdg fetch happens in the q half
      if (q_rise)
        video_byte <= src.ram;

      ras_n_r <= strobes.ras_n;
      cas_n_r <= strobes.cas_n;
      q_r     <= strobes.q;
    end
  end

endmodule

//--- cpu_data_mux.sv
// cpu read data multiplexer
module cpu_data_mux (
  input  coco_pkg::chip_sel_t sel,
  input  coco_pkg::rd_src_t   held,
  output logic [7:0]          cpu_din
);

  import coco_pkg::*;

  // decoder never raises two selects, coco and d64 sets are disjoint
  always_comb
  begin
    unique case (1'b1)
      sel.ram:     cpu_din = held.ram;
      sel.rom8:    cpu_din = held.rom8;      // coco extended basic
      sel.roma:    cpu_din = held.roma;      // coco color basic
      sel.rom8_b1: cpu_din = held.rom8;      // d64 bank 1
      sel.rom8_b2: cpu_din = held.rom8_alt;  // d64 bank 2
      sel.roma_b1: cpu_din = held.roma;
      sel.roma_b2: cpu_din = held.roma_alt;
      sel.romc:    cpu_din = held.romc;
      sel.pia0:    cpu_din = held.pia0;
      sel.acia:    cpu_din = held.acia;      // serial in the pia0 window
      sel.pia1:    cpu_din = held.pia1;
      sel.io:      cpu_din = held.io;
      default:     cpu_din = FLOAT_BYTE;
    endcase
  end

endmodule

//--- joystick_pos.sv
// joystick position from pad or analog stick
module joystick_pos (
  input  logic               clk,
  input  logic               reset_n,
  input  logic               use_dpad,  // buttons drive the position
  input  logic [3:0]         btn,       // up, down, left, right
  input  coco_pkg::joy_pos_t analog,
  output coco_pkg::joy_pos_t pos
);

  import coco_pkg::*;

  joy_pos_t pad_pos;

  always_comb
  begin
    pad_pos.x = JOY_CENTER;  // at rest
    pad_pos.y = JOY_CENTER;

    if (btn[0])
      pad_pos.x = JOY_HIGH;  // right
    if (btn[1])
      pad_pos.x = JOY_LOW;   // left, wins over right

    if (btn[2])
      pad_pos.y = JOY_HIGH;  // down
    if (btn[3])
      pad_pos.y = JOY_LOW;   // up, wins over down
  end

  // one clock to the comparator dac
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      pos.x <= JOY_CENTER;
      pos.y <= JOY_CENTER;
    end
    else if (use_dpad)
      pos <= pad_pos;
    else
      pos <= analog;
  end

endmodule

//--- coco_bus_glue.sv
// coco and dragon bus glue
module coco_bus_glue #(
  parameter int FAST_DIV = 2,  // turbo cadence
  parameter int SLOW_DIV = 3   // normal cadence
) (
  input  logic                   clk,
  input  logic                   reset_n,
  input  coco_pkg::machine_cfg_t cfg,
  input  logic [2:0]             dev_sel,
  input  coco_pkg::cpu_addr_u    addr,
  input  logic                   rw,              // cpu read/write, reads served here
  input  coco_pkg::dram_strobe_t strobes,
  input  logic [7:0]             dram_addr_byte,
  input  coco_pkg::rd_src_t      src,
  input  logic                   ddrb2,
  input  logic                   portb2,
  input  logic                   joy_use_dpad,
  input  logic [3:0]             joy1_btn,
  input  logic [3:0]             joy2_btn,
  input  coco_pkg::joy_pos_t     joya1,
  input  coco_pkg::joy_pos_t     joya2,
  output logic                   clk_ena,
  output coco_pkg::chip_sel_t    sel,
  output logic [7:0]             cpu_din,
  output logic [15:0]            sam_addr,
  output logic [7:0]             video_byte,
  output coco_pkg::joy_pos_t     joy1_pos,
  output coco_pkg::joy_pos_t     joy2_pos
);

  import coco_pkg::*;

  rd_src_t held;  // sources as of the last ras cycle

  clk_enable_gen #(
    .FAST_DIV (FAST_DIV),
    .SLOW_DIV (SLOW_DIV)
  ) u_clk_enable_gen (
    .clk     (clk),
    .reset_n (reset_n),
    .turbo   (cfg.turbo),
    .clk_ena (clk_ena)
  );

  chip_select_decode u_chip_select_decode (
    .cfg     (cfg),
    .dev_sel (dev_sel),
    .addr    (addr),
    .ddrb2   (ddrb2),
    .portb2  (portb2),
    .sel     (sel)
  );

  bus_latch u_bus_latch (
    .clk            (clk),
    .reset_n        (reset_n),
    .clk_ena        (clk_ena),
    .strobes        (strobes),
    .dram_addr_byte (dram_addr_byte),
    .src            (src),
    .held           (held),
    .sam_addr       (sam_addr),
    .video_byte     (video_byte)
  );

  cpu_data_mux u_cpu_data_mux (
    .sel     (sel),
    .held    (held),
    .cpu_din (cpu_din)
  );

  joystick_pos u_joy1 (
    .clk      (clk),
    .reset_n  (reset_n),
    .use_dpad (joy_use_dpad),
    .btn      (joy1_btn),
    .analog   (joya1),
    .pos      (joy1_pos)
  );

  joystick_pos u_joy2 (
    .clk      (clk),
    .reset_n  (reset_n),
    .use_dpad (joy_use_dpad),
    .btn      (joy2_btn),
    .analog   (joya2),
    .pos      (joy2_pos)
  );

endmodule

//--- coco_bus_glue_assert.sv
// bus glue select and enable checks
module coco_bus_glue_assert (
  input logic                   clk,
  input logic                   reset_n,
  input coco_pkg::machine_cfg_t cfg,
  input coco_pkg::chip_sel_t    sel,
  input logic                   clk_ena
);

  logic fail_seen = 1'b0;  // sticky, any assertion failed

  // one device on the bus at most
  a_sel_onehot: assert property (@(posedge clk) disable iff (!reset_n) $onehot0(sel))
    else
    begin
      fail_seen = 1'b1;
      $error("more than one chip select high");
    end

  // acia and rom banks exist only on the dragon 64
  a_coco_plain: assert property (@(posedge clk) disable iff (!reset_n)
    !cfg.dragon64 |-> !(sel.acia || sel.rom8_b1 || sel.rom8_b2 || sel.roma_b1 || sel.roma_b2))
    else
    begin
      fail_seen = 1'b1;
      $error("dragon 64 select high in coco mode");
    end

  // turbo switch may butt the two cadences together
  a_ena_single: assert property (@(posedge clk) disable iff (!reset_n)
    clk_ena |=> (!clk_ena || $changed(cfg.turbo)))
    else
    begin
      fail_seen = 1'b1;
      $error("clk_ena high on two consecutive clocks");
    end

endmodule

bind coco_bus_glue coco_bus_glue_assert u_assert (
  .clk     (clk),
  .reset_n (reset_n),
  .cfg     (cfg),
  .sel     (sel),
  .clk_ena (clk_ena)
);

//--- tb_coco_bus_glue.sv
// bus glue golden-vector testbench
module tb_coco_bus_glue;

  import coco_pkg::*;

  localparam int MAX_VEC = 64;

  logic         clk;
  logic         reset_n;
  machine_cfg_t cfg;
  logic [2:0]   dev_sel;
  cpu_addr_u    addr;
  logic         rw;
  dram_strobe_t strobes;
  logic [7:0]   dram_addr_byte;
  rd_src_t      src;
  logic         ddrb2;
  logic         portb2;
  logic         joy_use_dpad;
  logic [3:0]   joy1_btn;
  logic [3:0]   joy2_btn;
  joy_pos_t     joya1;
  joy_pos_t     joya2;
  logic         clk_ena;
  chip_sel_t    sel;
  logic [7:0]   cpu_din;
  logic [15:0]  sam_addr;
  logic [7:0]   video_byte;
  joy_pos_t     joy1_pos;
  joy_pos_t     joy2_pos;

  logic [15:0] golden [0:4*MAX_VEC-1];  // four words per vector
  int          n_vec;
  string       names [1:8] = '{"cadence", "chip_select", "read_path", "rom_bank",
                               "dram_addr", "video_byte", "joy_dpad", "joy_analog"};

  coco_bus_glue #(
    .FAST_DIV (2),
    .SLOW_DIV (3)
  ) DUT (.*);  // tb nets share the port names

  always #10 clk = ~clk;

  // drive and sample just after the rising edge
  task automatic tick(input int n);
    repeat (n) @(posedge clk);
    #2;
  endtask

  task automatic check(input string name, input logic [15:0] exp, input logic [15:0] act);
    if (act !== exp)
    begin
      $display("Error: %s expected %h actual %h", name, exp, act);
      $display("SOME TESTS FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // a = {ddrb2, portb2, a2, d64, dev_sel}
  task automatic apply_select(input logic [15:0] a, input logic d64);
    cfg.dragon     = d64;
    cfg.dragon64   = d64;
    dev_sel        = a[2:0];
    addr           = '0;
    addr.io.serial = a[4];  // pia0 or acia on the d64
    portb2         = a[5];
    ddrb2          = a[6];
  endtask

  task automatic run_vector(input int i);
    logic [15:0] code;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] exp;
    string       name;
    int          pulses;
    code = golden[4*i];
    a    = golden[4*i+1];
    b    = golden[4*i+2];
    exp  = golden[4*i+3];
    name = $sformatf("%s vector %0d", names[code], i);
    case (code)
      16'h1:
      begin
        cfg.turbo = a[0];
        tick(1);
        pulses = 0;
        repeat (60)
        begin
          if (clk_ena)
            pulses++;
          tick(1);
        end
        check(name, exp, 16'(pulses));
        cfg.turbo = 1'b0;
      end
      16'h2, 16'h4:
      begin
        apply_select(a, 1'b0);  // b holds the coco decode
        tick(1);
        check({name, " coco"}, b, 16'(sel));
        apply_select(a, 1'b1);
        tick(1);
        check({name, " d64"}, exp, 16'(sel));
      end
      16'h3:
      begin
        apply_select(a, a[3]);
        for (int k = 0; k < 10; k++)
          src[79-8*k -: 8] = 8'($urandom);  // unchecked sources
        src[79-8*b[11:8] -: 8] = b[7:0];    // b = {field index, byte}
        strobes.ras_n = 1'b0;
        strobes.e     = 1'b1;
        tick(8);
        strobes.ras_n = 1'b1;  // ras rise during e captures src
        tick(8);
        check(name, exp, 16'(cpu_din));
        strobes.e = 1'b0;
      end
      16'h5:
      begin
        dram_addr_byte = a[7:0];  // row
        strobes.ras_n  = 1'b0;
        tick(8);
        dram_addr_byte = b[7:0];  // column
        strobes.cas_n  = 1'b0;
        tick(8);
        check(name, exp, sam_addr);
        strobes.ras_n = 1'b1;
        strobes.cas_n = 1'b1;
        tick(8);
      end
      16'h6:
      begin
        src.ram   = a[7:0];
        strobes.q = 1'b0;
        tick(8);
        strobes.q = 1'b1;
        tick(8);
        check(name, exp, 16'(video_byte));
        strobes.q = 1'b0;
      end
      16'h7:
      begin
        joy_use_dpad = 1'b1;
        joy1_btn     = a[3:0];
        joy2_btn     = a[7:4];
        tick(2);
        check({name, " joy1"}, exp, joy1_pos);
        check({name, " joy2"}, b, joy2_pos);
      end
      16'h8:
      begin
        joy_use_dpad = 1'b0;
        joy1_btn     = 4'hF;  // ignored off the pad
        joy2_btn     = 4'hF;
        joya1        = a;
        joya2        = b;
        tick(2);
        check({name, " joy1"}, exp, joy1_pos);
        check({name, " joy2"}, b, joy2_pos);  // analog passes straight through
      end
      default:
      begin
        $display("Error: unknown test code %h in golden file at vector %0d", code, i);
        $display("SOME TESTS FAILED");
        $fatal(1, "bad golden file");
      end
    endcase
  endtask

  initial
  begin
    void'($urandom(59));
    clk            = 1'b0;
    reset_n        = 1'b0;
    cfg            = '0;
    dev_sel        = '0;
    addr           = '0;
    rw             = 1'b1;  // reads only
    strobes.ras_n  = 1'b1;
    strobes.cas_n  = 1'b1;
    strobes.e      = 1'b0;
    strobes.q      = 1'b0;
    dram_addr_byte = '0;
    src            = '0;
    ddrb2          = 1'b0;
    portb2         = 1'b0;
    joy_use_dpad   = 1'b0;
    joy1_btn       = '0;
    joy2_btn       = '0;
    joya1          = '0;
    joya2          = '0;
    for (int k = 0; k < 4*MAX_VEC; k++)
      golden[k] = '0;  // code 0 ends the list
    $readmemh("coco_golden.txt", golden);
    n_vec = 0;
    while (n_vec < MAX_VEC && golden[4*n_vec] != 16'h0)
      n_vec++;
    if (n_vec == 0)
    begin
      $display("Error: no vectors read from coco_golden.txt");
      $display("SOME TESTS FAILED");
      $fatal(1, "empty golden file");
    end
    repeat (10) @(posedge clk);
    #2;
    reset_n = 1'b1;
    for (int i = 0; i < n_vec; i++)
      run_vector(i);
    $display("ALL TESTS PASSED");
    $finish;
  end

  // 40 clocks per vector
  initial
  begin
    @(posedge reset_n);
    repeat (n_vec * 40) @(posedge clk);
    $display("Error: watchdog expired with vectors still running");
    $display("SOME TESTS FAILED");
    $fatal(1, "timeout");
  end

  initial
  begin
    wait (DUT.u_assert.fail_seen === 1'b1);  // raised by the bound checker
    $display("Error: a bound assertion on the DUT failed");
    $display("SOME TESTS FAILED");
    $fatal(1, "assertion failure");
  end

endmodule

//--- coco_golden.txt
// code stim_a stim_b expected, all hex, one vector per line
// 1 turbo/pulses, 2/4 a={ddrb2,portb2,a2,d64,dev} coco/d64 sel, 3 b={field,byte}
1 0 0 14
1 1 0 1E
2 00 800 800
2 01 400 008
2 02 200 002
2 03 100 100
2 04 080 080
2 14 080 010
2 05 040 040
2 06 020 020
2 07 000 000
4 29 400 008
4 49 400 004
4 69 400 008
4 4A 200 001
3 00 0A5 A5
3 01 13C 3C
3 04 47E 7E
3 06 642 42
3 07 000 FF
3 1C 7E7 E7
3 49 829 29
3 0A 25A 5A
5 34 12 1234
6 5A 0 5A
7 10 F080 8080
7 32 1080 1080
7 54 F0F0 80F0
7 76 10F0 10F0
7 98 F010 8010
7 BA 1010 1010
7 DC F010 8010
7 FE 1010 1010
8 3377 A0C0 3377

//--- sim.f
coco_pkg.sv
clk_enable_gen.sv
chip_select_decode.sv
bus_latch.sv
cpu_data_mux.sv
joystick_pos.sv
coco_bus_glue.sv
coco_bus_glue_assert.sv
tb_coco_bus_glue.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_coco_bus_glue
FILELIST  = sim.f
OBJ_DIR   = obj_dir
LOG       = sim.log

SOURCES = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
